// ==== common/system86_defs.svh ====
`ifndef SYSTEM86_DEFS_SVH
`define SYSTEM86_DEFS_SVH

// horizontal raster, in pixel clocks
`define SYS86_H_TOTAL       48
`define SYS86_H_ACTIVE      32
`define SYS86_HSYNC_START   36
`define SYS86_HSYNC_WIDTH   4
`define SYS86_H_BITS        6

// vertical raster, in lines
`define SYS86_V_TOTAL       20
`define SYS86_V_ACTIVE      16
`define SYS86_VSYNC_START   17
`define SYS86_VSYNC_WIDTH   2
`define SYS86_V_BITS        5

// tile layout, map of 64 x 32 pixels wrapping both ways
`define SYS86_TILE_SIZE     8
`define SYS86_MAP_COLS      8
`define SYS86_MAP_ROWS      4
`define SYS86_TILEMAP_ENTRIES (`SYS86_MAP_COLS * `SYS86_MAP_ROWS)
`define SYS86_SCROLL_X_BITS 6
`define SYS86_SCROLL_Y_BITS 5

// host address map
`define SYS86_HOST_ADDR_BITS   13
`define SYS86_HOST_OFFSET_BITS 9
`define SYS86_ADDR_TILEMAP     13'h000
`define SYS86_ADDR_SCROLL_X    13'h100
`define SYS86_ADDR_SCROLL_Y    13'h101
`define SYS86_ADDR_BACKCOLOR   13'h102
`define SYS86_ADDR_PALETTE     13'h200
`define SYS86_PALETTE_BYTES    512
`define SYS86_PALETTE_ENTRIES  256

`endif

// ==== common/system86_pkg.sv ====
package system86_pkg;

	////////////////////////////////////////
	// pixel and colour types
	////////////////////////////////////////

	// colour index out of the tile layer
	typedef logic [7:0] dot_t;

	// 4 bits per gun, as on the board's resistor DAC
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	////////////////////////////////////////
	// host write targets
	////////////////////////////////////////

	// none marks an unmapped address, never forwarded with we set
	typedef enum logic [2:0] {
		none      = 3'd0,
		tilemap   = 3'd1,
		scroll_x  = 3'd2,
		scroll_y  = 3'd3,
		backcolor = 3'd4,
		palette   = 3'd5
	} host_region_e;

endpackage

// ==== common/raster_if.sv ====
`include "system86_defs.svh"

// raster position and timing strobes, timing_gen to tilegen
interface raster_if;

	// beam position, aligned with the strobes below
	logic [`SYS86_H_BITS-1:0] hpos;
	logic [`SYS86_V_BITS-1:0] vpos;

	// all strobes active low
	logic hblank_n;
	logic vblank_n;
	logic hsync_n;
	logic vsync_n;

	modport src (
		output hpos,
		output vpos,
		output hblank_n,
		output vblank_n,
		output hsync_n,
		output vsync_n
	);

	modport dst (
		input hpos,
		input vpos,
		input hblank_n,
		input vblank_n,
		input hsync_n,
		input vsync_n
	);

endinterface

// ==== common/pixel_if.sv ====
// colour index plus strobes, tilegen to videogen
interface pixel_if;

	// one index per pixel clock
	system86_pkg::dot_t dot;

	// strobes delayed to line up with dot
	logic hblank_n;
	logic vblank_n;
	logic hsync_n;
	logic vsync_n;

	modport src (
		output dot,
		output hblank_n,
		output vblank_n,
		output hsync_n,
		output vsync_n
	);

	modport dst (
		input dot,
		input hblank_n,
		input vblank_n,
		input hsync_n,
		input vsync_n
	);

endinterface

// ==== common/host_wr_if.sv ====
`include "system86_defs.svh"

// registered host writes, fanned out to the memories
interface host_wr_if;

	// decoded target and offset inside it
	system86_pkg::host_region_e region;
	logic [`SYS86_HOST_OFFSET_BITS-1:0] offset;
	logic [7:0] data;

	// single cycle write strobe
	logic we;

	modport src (
		output region,
		output offset,
		output data,
		output we
	);

	// every receiver filters on its own region
	modport dst (
		input region,
		input offset,
		input data,
		input we
	);

endinterface

// ==== timing/timing_gen.sv ====
`include "system86_defs.svh"

module timing_gen (
	input  logic  clk,
	input  logic  rst_n,
	raster_if.src raster
);

	logic h_wrap;
	logic v_wrap;
	logic [`SYS86_H_BITS-1:0] h_next;
	logic [`SYS86_V_BITS-1:0] v_next;

	////////////////////////////////////////
	// next position
	////////////////////////////////////////

	// end of line / end of frame
	assign h_wrap = (raster.hpos == `SYS86_H_TOTAL - 1);
	assign v_wrap = (raster.vpos == `SYS86_V_TOTAL - 1);

	always_comb begin
		if (h_wrap) begin
			h_next = '0;
		end else begin
			h_next = raster.hpos + 1'b1;
		end
		// line counter steps only at end of line
		if (!h_wrap) begin
			v_next = raster.vpos;
		end else if (v_wrap) begin
			v_next = '0;
		end else begin
			v_next = raster.vpos + 1'b1;
		end
	end

	////////////////////////////////////////
	// counters and strobes
	////////////////////////////////////////

	// strobes decoded from next position, so they land with hpos/vpos
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			raster.hpos     <= '0;
			raster.vpos     <= '0;
			raster.hblank_n <= 1'b0;
			raster.vblank_n <= 1'b0;
			raster.hsync_n  <= 1'b1;
			raster.vsync_n  <= 1'b1;
		end else begin
			raster.hpos     <= h_next;
			raster.vpos     <= v_next;
			raster.hblank_n <= (h_next < `SYS86_H_ACTIVE);
			raster.vblank_n <= (v_next < `SYS86_V_ACTIVE);
			raster.hsync_n  <= !((h_next >= `SYS86_HSYNC_START) &&
				(h_next < `SYS86_HSYNC_START + `SYS86_HSYNC_WIDTH));
			raster.vsync_n  <= !((v_next >= `SYS86_VSYNC_START) &&
				(v_next < `SYS86_VSYNC_START + `SYS86_VSYNC_WIDTH));
		end
	end

	// sync pulse must sit inside horizontal blanking
	a_hsync_in_hblank : assert property (@(posedge clk) disable iff (!rst_n)
		!raster.hsync_n |-> !raster.hblank_n);

endmodule

// ==== tilegen/tilegen.sv ====
`include "system86_defs.svh"

module tilegen (
	input  logic                            clk,
	input  logic                            rst_n,
	raster_if.dst                           raster,
	host_wr_if.dst                          wr,
	input  logic [`SYS86_SCROLL_X_BITS-1:0] scroll_x,
	input  logic [`SYS86_SCROLL_Y_BITS-1:0] scroll_y,
	input  system86_pkg::dot_t              backcolor,
	pixel_if.src                            pix
);

	// tilemap ram, one code per 8x8 tile
	logic [7:0] tile_ram [0:`SYS86_TILEMAP_ENTRIES-1];

	logic [`SYS86_SCROLL_X_BITS-1:0] map_x;
	logic [`SYS86_SCROLL_Y_BITS-1:0] map_y;
	logic [2:0] map_col;
	logic [1:0] map_row;
	logic [4:0] tile_idx;
	logic [7:0] tile_code;
	system86_pkg::dot_t dot_d;

	////////////////////////////////////////
	// host writes
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr.we && (wr.region == system86_pkg::tilemap)) begin
			tile_ram[wr.offset[4:0]] <= wr.data;
		end
	end

	////////////////////////////////////////
	// scrolled lookup
	////////////////////////////////////////

	// wraparound falls out of the adder width
	assign map_x = raster.hpos + scroll_x;
	assign map_y = raster.vpos + scroll_y;

	assign map_col  = 3'(map_x / `SYS86_TILE_SIZE);
	assign map_row  = 2'(map_y / `SYS86_TILE_SIZE);
	assign tile_idx = 5'(map_row * `SYS86_MAP_COLS + map_col);

	assign tile_code = tile_ram[tile_idx];
	// code 0 is transparent, show background colour
	assign dot_d = (tile_code == 8'h00) ? backcolor : tile_code;

	// strobes follow the dot by one clock
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix.hblank_n <= 1'b0;
			pix.vblank_n <= 1'b0;
			pix.hsync_n  <= 1'b1;
			pix.vsync_n  <= 1'b1;
		end else begin
			pix.hblank_n <= raster.hblank_n;
			pix.vblank_n <= raster.vblank_n;
			pix.hsync_n  <= raster.hsync_n;
			pix.vsync_n  <= raster.vsync_n;
		end
	end

	always_ff @(posedge clk) begin
		pix.dot <= dot_d;
	end

	// decode in host_regs never hands over an entry past the map
	a_tile_offset : assert property (@(posedge clk) disable iff (!rst_n)
		(wr.we && (wr.region == system86_pkg::tilemap))
		|-> (wr.offset < `SYS86_TILEMAP_ENTRIES));

endmodule

// ==== videogen/videogen.sv ====
`include "system86_defs.svh"

module videogen (
	input  logic               clk,
	input  logic               rst_n,
	pixel_if.dst               pix,
	host_wr_if.dst             wr,
	output system86_pkg::rgb_t rgb,
	output logic               hsync_n,
	output logic               vsync_n,
	output logic               hblank_n,
	output logic               vblank_n,
	output logic               csync_n
);

	// palette held as two byte lanes, green/blue and red
	logic [7:0] pal_gb [0:`SYS86_PALETTE_ENTRIES-1];
	logic [3:0] pal_r  [0:`SYS86_PALETTE_ENTRIES-1];

	logic pal_we;
	logic [7:0] pal_idx;
	system86_pkg::rgb_t colour;

	////////////////////////////////////////
	// palette writes
	////////////////////////////////////////

	assign pal_we  = wr.we && (wr.region == system86_pkg::palette);
	// two bytes per entry
	assign pal_idx = wr.offset[8:1];

	always_ff @(posedge clk) begin
		if (pal_we && !wr.offset[0]) begin
			pal_gb[pal_idx] <= wr.data;
		end
		// odd byte only carries red in the low nibble
		if (pal_we && wr.offset[0]) begin
			pal_r[pal_idx] <= wr.data[3:0];
		end
	end

	////////////////////////////////////////
	// colour lookup and output stage
	////////////////////////////////////////

	always_comb begin
		colour.red   = pal_r[pix.dot];
		colour.green = pal_gb[pix.dot][7:4];
		colour.blue  = pal_gb[pix.dot][3:0];
	end

	// blanked pixels driven black
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rgb      <= '0;
			hblank_n <= 1'b0;
			vblank_n <= 1'b0;
			hsync_n  <= 1'b1;
			vsync_n  <= 1'b1;
			csync_n  <= 1'b1;
		end else begin
			rgb      <= (pix.hblank_n && pix.vblank_n) ? colour : '0;
			hblank_n <= pix.hblank_n;
			vblank_n <= pix.vblank_n;
			hsync_n  <= pix.hsync_n;
			vsync_n  <= pix.vsync_n;
			csync_n  <= pix.hsync_n & pix.vsync_n;
		end
	end

endmodule

// ==== logic/host_regs.sv ====
`include "system86_defs.svh"

module host_regs (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [`SYS86_HOST_ADDR_BITS-1:0] host_addr,
	input  logic [7:0]                       host_data,
	input  logic                             host_we,
	output logic [`SYS86_SCROLL_X_BITS-1:0]  scroll_x,
	output logic [`SYS86_SCROLL_Y_BITS-1:0]  scroll_y,
	output system86_pkg::dot_t               backcolor,
	host_wr_if.src                           wr
);

	logic [`SYS86_HOST_ADDR_BITS-1:0] tile_rel;
	logic [`SYS86_HOST_ADDR_BITS-1:0] pal_rel;
	system86_pkg::host_region_e region_d;
	logic [`SYS86_HOST_OFFSET_BITS-1:0] offset_d;

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	// below-base addresses wrap high and miss the range check
	assign tile_rel = host_addr - `SYS86_ADDR_TILEMAP;
	assign pal_rel  = host_addr - `SYS86_ADDR_PALETTE;

	always_comb begin
		region_d = system86_pkg::none;
		offset_d = '0;
		if (tile_rel < `SYS86_TILEMAP_ENTRIES) begin
			region_d = system86_pkg::tilemap;
			offset_d = tile_rel[`SYS86_HOST_OFFSET_BITS-1:0];
		end else if (host_addr == `SYS86_ADDR_SCROLL_X) begin
			region_d = system86_pkg::scroll_x;
		end else if (host_addr == `SYS86_ADDR_SCROLL_Y) begin
			region_d = system86_pkg::scroll_y;
		end else if (host_addr == `SYS86_ADDR_BACKCOLOR) begin
			region_d = system86_pkg::backcolor;
		end else if (pal_rel < `SYS86_PALETTE_BYTES) begin
			region_d = system86_pkg::palette;
			offset_d = pal_rel[`SYS86_HOST_OFFSET_BITS-1:0];
		end
	end

	// write stage, unmapped addresses dropped here
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr.region <= system86_pkg::none;
			wr.we     <= 1'b0;
		end else begin
			wr.region <= region_d;
			wr.we     <= host_we && (region_d != system86_pkg::none);
		end
	end

	always_ff @(posedge clk) begin
		wr.offset <= offset_d;
		wr.data   <= host_data;
	end

	////////////////////////////////////////
	// scroll and backcolor latches
	////////////////////////////////////////

	// loaded from the write stage, same latency as the rams
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scroll_x  <= '0;
			scroll_y  <= '0;
			backcolor <= '0;
		end else if (wr.we) begin
			if (wr.region == system86_pkg::scroll_x) begin
				scroll_x <= wr.data[`SYS86_SCROLL_X_BITS-1:0];
			end
			if (wr.region == system86_pkg::scroll_y) begin
				scroll_y <= wr.data[`SYS86_SCROLL_Y_BITS-1:0];
			end
			if (wr.region == system86_pkg::backcolor) begin
				backcolor <= wr.data;
			end
		end
	end

endmodule

// ==== logic/system86_video.sv ====
`include "system86_defs.svh"

module system86_video (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [`SYS86_HOST_ADDR_BITS-1:0] host_addr,
	input  logic [7:0]                       host_data,
	input  logic                             host_we,
	output logic [3:0]                       vid_red,
	output logic [3:0]                       vid_green,
	output logic [3:0]                       vid_blue,
	output logic                             vid_hsync_n,
	output logic                             vid_vsync_n,
	output logic                             vid_hblank_n,
	output logic                             vid_vblank_n,
	output logic                             vid_csync_n
);

	raster_if  raster ();
	pixel_if   pix ();
	host_wr_if wr ();

	logic [`SYS86_SCROLL_X_BITS-1:0] scroll_x;
	logic [`SYS86_SCROLL_Y_BITS-1:0] scroll_y;
	system86_pkg::dot_t backcolor;
	system86_pkg::rgb_t rgb;

	////////////////////////////////////////
	// video path
	////////////////////////////////////////

	timing_gen i_timing_gen (
		.clk    (clk),
		.rst_n  (rst_n),
		.raster (raster.src)
	);

	// cpu side write port
	host_regs i_host_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.host_addr (host_addr),
		.host_data (host_data),
		.host_we   (host_we),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.backcolor (backcolor),
		.wr        (wr.src)
	);

	tilegen i_tilegen (
		.clk       (clk),
		.rst_n     (rst_n),
		.raster    (raster.dst),
		.wr        (wr.dst),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.backcolor (backcolor),
		.pix       (pix.src)
	);

	// palette and output stage
	videogen i_videogen (
		.clk      (clk),
		.rst_n    (rst_n),
		.pix      (pix.dst),
		.wr       (wr.dst),
		.rgb      (rgb),
		.hsync_n  (vid_hsync_n),
		.vsync_n  (vid_vsync_n),
		.hblank_n (vid_hblank_n),
		.vblank_n (vid_vblank_n),
		.csync_n  (vid_csync_n)
	);

	// split the colour word into guns
	assign vid_red   = rgb.red;
	assign vid_green = rgb.green;
	assign vid_blue  = rgb.blue;

endmodule

// ==== verification/tb_system86.sv ====
`include "system86_defs.svh"

module tb_system86;

	localparam int FRAME_CYC = `SYS86_H_TOTAL * `SYS86_V_TOTAL;
	localparam int NUM_CFG   = 12;
	// three frames per configuration plus the palette fill and start-up
	localparam int CYCLE_LIMIT = (NUM_CFG * 3 + 6) * FRAME_CYC;
	localparam int MAP_W = `SYS86_TILE_SIZE * `SYS86_MAP_COLS;
	localparam int MAP_H = `SYS86_TILE_SIZE * `SYS86_MAP_ROWS;

	logic clk = 1'b0;
	logic rst_n;
	logic [`SYS86_HOST_ADDR_BITS-1:0] host_addr;
	logic [7:0] host_data;
	logic host_we;
	logic [3:0] vid_red;
	logic [3:0] vid_green;
	logic [3:0] vid_blue;
	logic vid_hsync_n;
	logic vid_vsync_n;
	logic vid_hblank_n;
	logic vid_vblank_n;
	logic vid_csync_n;

	// reference model of the video state
	logic [7:0] m_tile   [0:`SYS86_TILEMAP_ENTRIES-1];
	logic [7:0] m_pal_gb [0:`SYS86_PALETTE_ENTRIES-1];
	logic [3:0] m_pal_r  [0:`SYS86_PALETTE_ENTRIES-1];
	logic [`SYS86_SCROLL_X_BITS-1:0] m_scroll_x;
	logic [`SYS86_SCROLL_Y_BITS-1:0] m_scroll_y;
	logic [7:0] m_backcolor;

	// beam position recovered from the output strobes
	int h_cnt;
	int line_cnt;
	int frames;
	logic hb_q;
	logic vb_q;
	logic pix_check;
	int cycles = 0;
	int errors;
	int unsigned seed;
	int unsigned rnd;

	system86_video i_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.host_addr    (host_addr),
		.host_data    (host_data),
		.host_we      (host_we),
		.vid_red      (vid_red),
		.vid_green    (vid_green),
		.vid_blue     (vid_blue),
		.vid_hsync_n  (vid_hsync_n),
		.vid_vsync_n  (vid_vsync_n),
		.vid_hblank_n (vid_hblank_n),
		.vid_vblank_n (vid_vblank_n),
		.vid_csync_n  (vid_csync_n)
	);

	always #4 clk = ~clk;

	// hard stop on a hung raster or a stuck wait loop
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles before the tests completed", cycles);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	////////////////////////////////////////
	// checks and model
	////////////////////////////////////////

	task automatic expect_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR %s expected %h got %h", name, exp, got);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// host address map applied to the model
	function automatic void model_write(input logic [12:0] addr, input logic [7:0] data);
		int off;
		if (addr < `SYS86_ADDR_TILEMAP + `SYS86_TILEMAP_ENTRIES) begin
			m_tile[addr - `SYS86_ADDR_TILEMAP] = data;
		end else if (addr == `SYS86_ADDR_SCROLL_X) begin
			m_scroll_x = data[`SYS86_SCROLL_X_BITS-1:0];
		end else if (addr == `SYS86_ADDR_SCROLL_Y) begin
			m_scroll_y = data[`SYS86_SCROLL_Y_BITS-1:0];
		end else if (addr == `SYS86_ADDR_BACKCOLOR) begin
			m_backcolor = data;
		end else if (addr >= `SYS86_ADDR_PALETTE &&
			addr < `SYS86_ADDR_PALETTE + `SYS86_PALETTE_BYTES) begin
			off = addr - `SYS86_ADDR_PALETTE;
			// even byte green/blue, odd byte red in low nibble
			if (off % 2 == 0) begin
				m_pal_gb[off / 2] = data;
			end else begin
				m_pal_r[off / 2] = data[3:0];
			end
		end
	endfunction

	function automatic bit is_mapped(input logic [12:0] addr);
		return (addr < `SYS86_ADDR_TILEMAP + `SYS86_TILEMAP_ENTRIES) ||
			(addr >= `SYS86_ADDR_SCROLL_X && addr <= `SYS86_ADDR_BACKCOLOR) ||
			(addr >= `SYS86_ADDR_PALETTE &&
			addr < `SYS86_ADDR_PALETTE + `SYS86_PALETTE_BYTES);
	endfunction

	// scrolled map lookup, code 0 falls back to backcolor
	function automatic logic [11:0] expected_rgb(input int h, input int v);
		int col;
		int row;
		logic [7:0] code;
		logic [7:0] idx;
		col = ((h + m_scroll_x) % MAP_W) / `SYS86_TILE_SIZE;
		row = ((v + m_scroll_y) % MAP_H) / `SYS86_TILE_SIZE;
		code = m_tile[row * `SYS86_MAP_COLS + col];
		idx = (code == 8'h00) ? m_backcolor : code;
		return {m_pal_r[idx], m_pal_gb[idx]};
	endfunction

	task automatic check_reset_state();
		expect_equal("vid_hsync_n", vid_hsync_n, 1'b1);
		expect_equal("vid_vsync_n", vid_vsync_n, 1'b1);
		expect_equal("vid_csync_n", vid_csync_n, 1'b1);
		expect_equal("vid_hblank_n", vid_hblank_n, 1'b0);
		expect_equal("vid_vblank_n", vid_vblank_n, 1'b0);
		expect_equal("vid_rgb", {vid_red, vid_green, vid_blue}, 12'h000);
	endtask

	// strobes and colour against the geometry at the tracked position
	task automatic check_outputs();
		logic exp_hb;
		logic exp_vb;
		logic exp_hs;
		logic exp_vs;
		logic [11:0] got_rgb;
		exp_hb = (h_cnt < `SYS86_H_ACTIVE);
		exp_vb = (line_cnt < `SYS86_V_ACTIVE);
		exp_hs = !(h_cnt >= `SYS86_HSYNC_START &&
			h_cnt < `SYS86_HSYNC_START + `SYS86_HSYNC_WIDTH);
		exp_vs = !(line_cnt >= `SYS86_VSYNC_START &&
			line_cnt < `SYS86_VSYNC_START + `SYS86_VSYNC_WIDTH);
		got_rgb = {vid_red, vid_green, vid_blue};
		expect_equal("vid_hblank_n", vid_hblank_n, exp_hb);
		expect_equal("vid_vblank_n", vid_vblank_n, exp_vb);
		expect_equal("vid_hsync_n", vid_hsync_n, exp_hs);
		expect_equal("vid_vsync_n", vid_vsync_n, exp_vs);
		expect_equal("vid_csync_n", vid_csync_n, exp_hs & exp_vs);
		if (!exp_hb || !exp_vb) begin
			expect_equal("vid_rgb", got_rgb, 12'h000);
		end else if (pix_check) begin
			expect_equal("vid_rgb", got_rgb, expected_rgb(h_cnt, line_cnt));
		end
	endtask

	////////////////////////////////////////
	// clocking and host access
	////////////////////////////////////////

	// one pixel clock, sampled on the falling edge
	task automatic step_clock();
		logic hb;
		logic vb;
		@(negedge clk);
		hb = vid_hblank_n;
		vb = vid_vblank_n;
		if (hb && !hb_q) begin
			if (frames >= 2) begin
				expect_equal("vid_hblank_n period", h_cnt + 1, `SYS86_H_TOTAL);
			end
			h_cnt = 0;
			if (vb && !vb_q) begin
				if (frames >= 2) begin
					expect_equal("vid_vblank_n period", line_cnt + 1, `SYS86_V_TOTAL);
				end
				line_cnt = 0;
				frames++;
			end else begin
				line_cnt++;
			end
		end else begin
			h_cnt++;
		end
		hb_q = hb;
		vb_q = vb;
		// first frame after reset starts one pixel late, skip it
		if (frames >= 2) begin
			check_outputs();
		end
	endtask

	// writes only in the first three vblank lines, well clear of the next frame
	task automatic host_write(input logic [12:0] addr, input logic [7:0] data);
		while (!(frames >= 2 && line_cnt >= `SYS86_V_ACTIVE &&
			line_cnt < `SYS86_V_TOTAL - 1)) begin
			step_clock();
		end
		host_addr = addr;
		host_data = data;
		host_we   = 1'b1;
		model_write(addr, data);
		step_clock();
		host_we = 1'b0;
	endtask

	// every active pixel of the next frame against the model
	task automatic check_frame();
		int start;
		start = frames;
		pix_check = 1'b1;
		while (frames == start) begin
			step_clock();
		end
		while (line_cnt < `SYS86_V_ACTIVE) begin
			step_clock();
		end
		pix_check = 1'b0;
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		logic [12:0] addr;
		rst_n     = 1'b0;
		host_addr = '0;
		host_data = '0;
		host_we   = 1'b0;
		h_cnt = 0;
		line_cnt = 0;
		frames = 0;
		hb_q = 1'b0;
		vb_q = 1'b0;
		pix_check = 1'b0;
		errors = 0;
		m_scroll_x = '0;
		m_scroll_y = '0;
		m_backcolor = '0;
		seed = 32'h8ab1_5257;
		rnd = $urandom(seed);

		// reset held for 8 clocks, outputs idle throughout
		repeat (8) begin
			step_clock();
			check_reset_state();
		end
		rst_n = 1'b1;
		step_clock();
		check_reset_state();

		// geometry checked by step_clock over a few whole frames
		while (frames < 4) begin
			step_clock();
		end

		for (int i = 0; i < `SYS86_PALETTE_BYTES; i++) begin
			host_write(13'(`SYS86_ADDR_PALETTE + i), 8'($urandom()));
		end

		// tile lookup with random scroll
		for (int cfg = 0; cfg < NUM_CFG; cfg++) begin
			for (int i = 0; i < `SYS86_TILEMAP_ENTRIES; i++) begin
				host_write(13'(`SYS86_ADDR_TILEMAP + i), 8'($urandom()));
			end
			host_write(`SYS86_ADDR_SCROLL_X, 8'($urandom()));
			host_write(`SYS86_ADDR_SCROLL_Y, 8'($urandom()));
			check_frame();
		end

		// transparent codes show backcolor
		repeat (3) begin
			for (int i = 0; i < `SYS86_TILEMAP_ENTRIES; i++) begin
				rnd = $urandom();
				host_write(13'(`SYS86_ADDR_TILEMAP + i), rnd[8] ? 8'h00 : rnd[7:0]);
			end
			host_write(`SYS86_ADDR_BACKCOLOR, 8'($urandom()));
			check_frame();
		end

		// unmapped writes must leave the picture alone
		repeat (24) begin
			addr = 13'($urandom());
			while (is_mapped(addr)) begin
				addr = 13'($urandom());
			end
			host_write(addr, 8'($urandom()));
		end
		check_frame();

		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== system86.f ====
+incdir+common
common/system86_pkg.sv
common/raster_if.sv
common/pixel_if.sv
common/host_wr_if.sv
timing/timing_gen.sv
tilegen/tilegen.sv
videogen/videogen.sv
logic/host_regs.sv
logic/system86_video.sv
verification/tb_system86.sv

// ==== Bender.yml ====
package:
  name: system86

export_include_dirs:
  - common

sources:
  - common/system86_pkg.sv
  - common/raster_if.sv
  - common/pixel_if.sv
  - common/host_wr_if.sv
  - timing/timing_gen.sv
  - tilegen/tilegen.sv
  - videogen/videogen.sv
  - logic/host_regs.sv
  - logic/system86_video.sv
  - target: test
    files:
      - verification/tb_system86.sv
